// ==== recorder.f ====
+incdir+logic
logic/rec_ctrl_pkg.sv
logic/audio_pkg.sv
logic/debounce.sv
logic/rec_fsm.sv
logic/sample_timer.sv
logic/sample_store.sv
logic/seven_seg.sv
logic/recorder_top.sv
verif/recorder_assert.sv
verif/recorder_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing
TOP       ?= recorder_tb
FILELIST  ?= recorder.f
OBJ_DIR   ?= obj_dir
RUN_ARGS  ?= +verilator+error+limit+100
PASS_TEXT := TEST PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee /dev/stderr | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/recorder_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "recorder_consts.svh"

module recorder_tb
	import rec_ctrl_pkg::*;
	import audio_pkg::*;
();

	localparam logic [31:0] SEED = 32'ha497_41a5;
	localparam int WAIT_LIMIT = 100;
	localparam int REQ_LIMIT = 1000;
	localparam int KEY_REC = 0;
	localparam int KEY_PLAY = 1;
	localparam int KEY_STOP = 2;

	logic       clk = 1'b0;
	logic       rst;
	logic       key_rec;
	logic       key_play;
	logic       key_stop;
	play_mode_t mode;
	logic       adc_valid;
	sample_t    adc_sample;
	logic       dac_req;
	logic       dac_valid;
	sample_t    dac_sample;
	rec_state_t dut_state;
	seconds_t   rec_time;
	seconds_t   play_time;
	logic [6:0] hex_rec_tens;
	logic [6:0] hex_rec_ones;
	logic [6:0] hex_play_tens;
	logic [6:0] hex_play_ones;

	// recorded take as the store should hold it
	sample_t     rec_q[$];
	logic [31:0] rng_state;
	int          out_total = 0;
	int          play_base;
	int          err_sample = 0;
	int          err_state;
	int          err_time;
	int          err_digit;
	int          err_other;

	recorder_top DUT (
		.i_clk           (clk),
		.i_rst           (rst),
		.i_key_rec       (key_rec),
		.i_key_play      (key_play),
		.i_key_stop      (key_stop),
		.i_mode          (mode),
		.i_adc_valid     (adc_valid),
		.i_adc_sample    (adc_sample),
		.i_dac_req       (dac_req),
		.o_dac_valid     (dac_valid),
		.o_dac_sample    (dac_sample),
		.o_state         (dut_state),
		.o_rec_time      (rec_time),
		.o_play_time     (play_time),
		.o_hex_rec_tens  (hex_rec_tens),
		.o_hex_rec_ones  (hex_rec_ones),
		.o_hex_play_tens (hex_play_tens),
		.o_hex_play_ones (hex_play_ones)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic sample_t next_sample();
		rng_state = xorshift(rng_state);
		return sample_t'(rng_state[15:0]);
	endfunction

	// expected sample for request k, false once past the recorded length
	function automatic bit ref_sample(input int k, input play_mode_t m, input int len,
			output sample_t s);
		int idx;
		if (m.fast) begin
			idx = k * (int'(m.speed) + 1);
		end else begin
			idx = k / (int'(m.speed) + 1);
		end
		s = '0;
		if (idx < len) begin
			s = rec_q[idx];
		end
		return idx < len;
	endfunction

	function automatic int ref_count(input play_mode_t m, input int len);
		int n;
		sample_t s;
		n = 0;
		while (ref_sample(n, m, len, s)) begin
			n++;
		end
		return n;
	endfunction

	function automatic seconds_t ref_seconds(input int pulses);
		int s;
		s = pulses / `SAMPLES_PER_TICK;
		if (s > 63) begin
			s = 63;
		end
		return seconds_t'(s);
	endfunction

	// lit segments gfedcba per digit, inverted since the display is active low
	function automatic logic [6:0] digit_pattern(input int d);
		logic [6:0] lit;
		case (d)
			0: lit = 7'h3f;
			1: lit = 7'h06;
			2: lit = 7'h5b;
			3: lit = 7'h4f;
			4: lit = 7'h66;
			5: lit = 7'h6d;
			6: lit = 7'h7d;
			7: lit = 7'h07;
			8: lit = 7'h7f;
			9: lit = 7'h6f;
			default: lit = 7'h00;
		endcase
		return ~lit;
	endfunction

	task automatic check_sample(input string name, input sample_t got, input sample_t exp);
		if (got !== exp) begin
			$display("FAILED time=%0t %s got=%0d expected=%0d", $time, name, got, exp);
			err_sample++;
		end
	endtask

	task automatic check_state(input string name, input rec_state_t got,
			input rec_state_t exp);
		if (got !== exp) begin
			$display("FAILED time=%0t %s got=%s expected=%s", $time, name, got.name(),
				exp.name());
			err_state++;
		end
	endtask

	task automatic check_seconds(input string name, input seconds_t got, input seconds_t exp);
		if (got !== exp) begin
			$display("FAILED time=%0t %s got=%0d expected=%0d", $time, name, got, exp);
			err_time++;
		end
	endtask

	task automatic check_digit(input string name, input logic [6:0] got,
			input logic [6:0] exp);
		if (got !== exp) begin
			$display("FAILED time=%0t %s got=%b expected=%b", $time, name, got, exp);
			err_digit++;
		end
	endtask

	task automatic check_displays(input seconds_t rec_s, input seconds_t play_s);
		check_seconds("o_rec_time", rec_time, rec_s);
		check_seconds("o_play_time", play_time, play_s);
		check_digit("o_hex_rec_tens", hex_rec_tens, digit_pattern(rec_s / 10));
		check_digit("o_hex_rec_ones", hex_rec_ones, digit_pattern(rec_s % 10));
		check_digit("o_hex_play_tens", hex_play_tens, digit_pattern(play_s / 10));
		check_digit("o_hex_play_ones", hex_play_ones, digit_pattern(play_s % 10));
	endtask

	// an answer to the last request is counted two edges later
	task automatic check_output_count(input int exp);
		repeat (2) @(posedge clk);
		if (out_total - play_base != exp) begin
			$display("playback gave %0d outputs where %0d were expected",
				out_total - play_base, exp);
			err_other++;
		end
	endtask

	task automatic end_run();
		int assert_errs;
		assert_errs = DUT.fsm0.fsm_chk.err_cnt;
		$display("errors: sample %0d, state %0d, time %0d, digit %0d, other %0d, assert %0d",
			err_sample, err_state, err_time, err_digit, err_other, assert_errs);
		if (err_sample + err_state + err_time + err_digit + err_other + assert_errs == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	endtask

	task automatic timeout_fail(input string what);
		$display("timeout at %0t while waiting for %s", $time, what);
		err_other++;
		end_run();
	endtask

	task automatic wait_state(input rec_state_t want);
		int cycles;
		cycles = 0;
		while (dut_state !== want && cycles < WAIT_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		if (dut_state !== want) begin
			timeout_fail($sformatf("state %s", want.name()));
		end
	endtask

	// hold a key low past the debounce time, then release and let it rearm
	task automatic press_key(input int which);
		@(posedge clk);
		case (which)
			KEY_REC: key_rec <= 1'b0;
			KEY_PLAY: key_play <= 1'b0;
			default: key_stop <= 1'b0;
		endcase
		repeat (`DEBOUNCE_CYCLES + 4) @(posedge clk);
		key_rec  <= 1'b1;
		key_play <= 1'b1;
		key_stop <= 1'b1;
		repeat (2) @(posedge clk);
	endtask

	task automatic send_request();
		@(posedge clk);
		dac_req <= 1'b1;
		@(posedge clk);
		dac_req <= 1'b0;
	endtask

	task automatic record_samples(input int n, input bit keep);
		sample_t s;
		repeat (n) begin
			s = next_sample();
			@(posedge clk);
			adc_valid  <= 1'b1;
			adc_sample <= s;
			// nothing lands once paused or full
			if (keep && rec_q.size() < `MEM_DEPTH) begin
				rec_q.push_back(s);
			end
			@(posedge clk);
			adc_valid <= 1'b0;
		end
	endtask

	task automatic start_take();
		rec_q.delete();
		press_key(KEY_REC);
		wait_state(RECORD);
	endtask

	task automatic stop_take();
		press_key(KEY_STOP);
		wait_state(IDLE);
	endtask

	// one playback from start to its own end
	task automatic play_take(input logic fast, input logic [2:0] speed);
		play_mode_t m;
		int cycles;
		int n;
		m.fast  = fast;
		m.speed = speed;
		n = ref_count(m, rec_q.size());
		@(posedge clk);
		mode <= m;
		play_base = out_total;
		press_key(KEY_PLAY);
		wait_state(PLAY);
		cycles = 0;
		while (dut_state !== IDLE && cycles < REQ_LIMIT) begin
			send_request();
			cycles++;
		end
		if (dut_state !== IDLE) begin
			timeout_fail("end of playback");
		end else begin
			// requests past the end stay unanswered
			repeat (3) send_request();
			check_output_count(n);
			check_seconds("o_play_time", play_time, ref_seconds(n));
		end
	endtask

	// compare process
	always @(posedge clk) begin
		sample_t exp_s;
		if (!rst && dac_valid) begin
			if (ref_sample(out_total - play_base, mode, rec_q.size(), exp_s)) begin
				check_sample("o_dac_sample", dac_sample, exp_s);
			end else begin
				$display("unexpected o_dac_valid at %0t for request %0d", $time,
					out_total - play_base);
				err_sample++;
			end
			out_total <= out_total + 1;
		end
	end

	initial begin
		rst        = 1'b1;
		key_rec    = 1'b1;
		key_play   = 1'b1;
		key_stop   = 1'b1;
		mode       = '0;
		adc_valid  = 1'b0;
		adc_sample = '0;
		dac_req    = 1'b0;
		rng_state  = SEED;
		play_base  = 0;
		err_state  = 0;
		err_time   = 0;
		err_digit  = 0;
		err_other  = 0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		repeat (3) @(posedge clk);

		// quiet after reset
		check_state("o_state", dut_state, IDLE);
		check_displays('0, '0);
		repeat (3) send_request();
		check_output_count(0);

		// plain take, then normal speed
		start_take();
		record_samples(40, 1'b1);
		stop_take();
		check_displays(ref_seconds(rec_q.size()), '0);
		play_take(1'b0, 3'd0);

		// skipping and repeating playback
		play_take(1'b1, 3'd2);
		play_take(1'b0, 3'd1);
		check_displays(ref_seconds(rec_q.size()), ref_seconds(rec_q.size() * 2));

		// strobes during record pause
		start_take();
		record_samples(10, 1'b1);
		press_key(KEY_REC);
		wait_state(REC_PAUSE);
		record_samples(5, 1'b0);
		press_key(KEY_REC);
		wait_state(RECORD);
		record_samples(10, 1'b1);
		stop_take();
		check_seconds("o_rec_time", rec_time, ref_seconds(rec_q.size()));
		play_take(1'b0, 3'd0);

		// stop in the middle of playback
		play_base = out_total;
		press_key(KEY_PLAY);
		wait_state(PLAY);
		repeat (5) send_request();
		stop_take();
		repeat (3) send_request();
		check_output_count(5);

		// overfill the memory
		start_take();
		record_samples(300, 1'b1);
		check_state("o_state", dut_state, IDLE);
		play_take(1'b0, 3'd0);
		check_displays(ref_seconds(rec_q.size()), ref_seconds(rec_q.size()));

		end_run();
	end

endmodule

bind rec_fsm recorder_assert fsm_chk (
	.i_clk   (i_clk),
	.i_rst   (i_rst),
	.i_state (o_state),
	.i_ctrl  (o_ctrl)
);

`default_nettype wire

// ==== verif/recorder_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module recorder_assert
	import rec_ctrl_pkg::*;
(
	input logic        i_clk,
	input logic        i_rst,
	input rec_state_t  i_state,
	input store_ctrl_t i_ctrl
);

	int err_cnt = 0;

	// the store is never written and read in the same take
	a_en_excl: assert property (@(posedge i_clk) disable iff (i_rst)
		!(i_ctrl.rec_en && i_ctrl.play_en))
		else begin
			$error("rec_en and play_en high together");
			err_cnt++;
		end

	a_rec_clear_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
		i_ctrl.rec_clear |=> !i_ctrl.rec_clear)
		else begin
			$error("rec_clear longer than one cycle");
			err_cnt++;
		end

	a_reset_idle: assert property (@(posedge i_clk)
		i_rst |=> (i_state == IDLE))
		else begin
			$error("state not IDLE after reset");
			err_cnt++;
		end

endmodule

`default_nettype wire

// ==== logic/recorder_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module recorder_top
	import rec_ctrl_pkg::*;
	import audio_pkg::*;
(
	input  logic       i_clk,
	input  logic       i_rst,
	input  logic       i_key_rec,
	input  logic       i_key_play,
	input  logic       i_key_stop,
	input  play_mode_t i_mode,
	input  logic       i_adc_valid,
	input  sample_t    i_adc_sample,
	input  logic       i_dac_req,
	output logic       o_dac_valid,
	output sample_t    o_dac_sample,
	output rec_state_t o_state,
	output seconds_t   o_rec_time,
	output seconds_t   o_play_time,
	output logic [6:0] o_hex_rec_tens,
	output logic [6:0] o_hex_rec_ones,
	output logic [6:0] o_hex_play_tens,
	output logic [6:0] o_hex_play_ones
);

	wire key_strobe_t keys;
	wire store_ctrl_t ctrl;
	wire logic        full;
	wire logic        play_end;
	wire logic        wr_stb;
	wire logic        rd_stb;

	// record/pause key
	debounce deb_rec (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_key   (i_key_rec),
		.o_press (keys.record)
	);

	// play/pause key
	debounce deb_play (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_key   (i_key_play),
		.o_press (keys.play)
	);

	debounce deb_stop (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_key   (i_key_stop),
		.o_press (keys.stop)
	);

	rec_fsm fsm0 (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_keys  (keys),
		.i_full  (full),
		.i_end   (play_end),
		.o_state (o_state),
		.o_ctrl  (ctrl)
	);

	sample_store store0 (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_ctrl       (ctrl),
		.i_mode       (i_mode),
		.i_adc_valid  (i_adc_valid),
		.i_adc_sample (i_adc_sample),
		.i_dac_req    (i_dac_req),
		.o_dac_valid  (o_dac_valid),
		.o_dac_sample (o_dac_sample),
		.o_wr_stb     (wr_stb),
		.o_rd_stb     (rd_stb),
		.o_full       (full),
		.o_end        (play_end)
	);

	sample_timer timer0 (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_ctrl      (ctrl),
		.i_wr_stb    (wr_stb),
		.i_rd_stb    (rd_stb),
		.o_rec_time  (o_rec_time),
		.o_play_time (o_play_time)
	);

	seven_seg seg_rec (
		.i_seconds (o_rec_time),
		.o_tens    (o_hex_rec_tens),
		.o_ones    (o_hex_rec_ones)
	);

	seven_seg seg_play (
		.i_seconds (o_play_time),
		.o_tens    (o_hex_play_tens),
		.o_ones    (o_hex_play_ones)
	);

endmodule

`default_nettype wire

// ==== logic/seven_seg.sv ====
`timescale 1ns/1ps
`default_nettype none

module seven_seg
	import audio_pkg::*;
(
	input  seconds_t   i_seconds,
	output logic [6:0] o_tens,
	output logic [6:0] o_ones
);

	logic [3:0] tens;
	logic [3:0] ones;

	// segments gfedcba, low means lit
	function automatic logic [6:0] seg_map(input logic [3:0] digit);
		case (digit)
			4'd0: seg_map = 7'b1000000;
			4'd1: seg_map = 7'b1111001;
			4'd2: seg_map = 7'b0100100;
			4'd3: seg_map = 7'b0110000;
			4'd4: seg_map = 7'b0011001;
			4'd5: seg_map = 7'b0010010;
			4'd6: seg_map = 7'b0000010;
			4'd7: seg_map = 7'b1111000;
			4'd8: seg_map = 7'b0000000;
			4'd9: seg_map = 7'b0010000;
			default: seg_map = 7'b1111111;
		endcase
	endfunction

	assign tens   = 4'(i_seconds / 6'd10);
	assign ones   = 4'(i_seconds % 6'd10);
	assign o_tens = seg_map(tens);
	assign o_ones = seg_map(ones);

endmodule

`default_nettype wire

// ==== logic/sample_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "recorder_consts.svh"

module sample_store
	import rec_ctrl_pkg::*;
	import audio_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_rst,
	input  store_ctrl_t i_ctrl,
	input  play_mode_t  i_mode,
	input  logic        i_adc_valid,
	input  sample_t     i_adc_sample,
	input  logic        i_dac_req,
	output logic        o_dac_valid,
	output sample_t     o_dac_sample,
	output logic        o_wr_stb,
	output logic        o_rd_stb,
	output logic        o_full,
	output logic        o_end
);

	// one extra bit so a full memory is distinct from empty
	localparam int LEN_W = `ADDR_W + 1;

	sample_t          mem [`MEM_DEPTH];
	logic [LEN_W-1:0] wr_ptr;
	logic [LEN_W-1:0] rd_ptr;
	logic [2:0]       rep_cnt;
	addr_t            wr_addr;
	addr_t            rd_addr;
	logic             wr_ok;
	logic             rd_ok;

	assign wr_addr = wr_ptr[`ADDR_W-1:0];
	assign rd_addr = rd_ptr[`ADDR_W-1:0];

	// write pointer doubles as record length
	assign o_full = (wr_ptr == LEN_W'(`MEM_DEPTH));
	assign o_end  = (rd_ptr >= wr_ptr);
	assign wr_ok  = i_ctrl.rec_en && i_adc_valid && !o_full;
	assign rd_ok  = i_ctrl.play_en && i_dac_req && !o_end;

	assign o_wr_stb = wr_ok;
	assign o_rd_stb = o_dac_valid;

	always_ff @(posedge i_clk) begin
		if (wr_ok) begin
			mem[wr_addr] <= i_adc_sample;
		end
		if (rd_ok) begin
			o_dac_sample <= mem[rd_addr];
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			rep_cnt     <= '0;
			o_dac_valid <= 1'b0;
		end else begin
			o_dac_valid <= rd_ok;
			if (i_ctrl.rec_clear) begin
				wr_ptr <= '0;
			end else if (wr_ok) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (i_ctrl.play_clear) begin
				rd_ptr  <= '0;
				rep_cnt <= '0;
			end else if (rd_ok) begin
				if (i_mode.fast) begin
					// skip ahead speed + 1 samples
					rd_ptr <= rd_ptr + LEN_W'(i_mode.speed) + 1'b1;
				end else if (rep_cnt == i_mode.speed) begin
					rep_cnt <= '0;
					rd_ptr  <= rd_ptr + 1'b1;
				end else begin
					rep_cnt <= rep_cnt + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/sample_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "recorder_consts.svh"

module sample_timer
	import rec_ctrl_pkg::*;
	import audio_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_rst,
	input  store_ctrl_t i_ctrl,
	input  logic        i_wr_stb,
	input  logic        i_rd_stb,
	output seconds_t    o_rec_time,
	output seconds_t    o_play_time
);

	localparam int SUB_W = $clog2(`SAMPLES_PER_TICK);
	localparam seconds_t SEC_MAX = '1;

	// channel 0 is recording, channel 1 is playback
	logic [SUB_W-1:0] sub_cnt [2];
	seconds_t         sec_cnt [2];
	logic [1:0]       stb;
	logic [1:0]       clr;

	assign stb = {i_rd_stb, i_wr_stb};
	assign clr = {i_ctrl.play_clear, i_ctrl.rec_clear};

	always_ff @(posedge i_clk) begin
		for (int i = 0; i < 2; i++) begin
			if (i_rst || clr[i]) begin
				sub_cnt[i] <= '0;
				sec_cnt[i] <= '0;
			end else if (stb[i]) begin
				if (sub_cnt[i] == SUB_W'(`SAMPLES_PER_TICK - 1)) begin
					sub_cnt[i] <= '0;
					if (sec_cnt[i] != SEC_MAX) begin
						sec_cnt[i] <= sec_cnt[i] + 1'b1;
					end
				end else begin
					sub_cnt[i] <= sub_cnt[i] + 1'b1;
				end
			end
		end
	end

	assign o_rec_time  = sec_cnt[0];
	assign o_play_time = sec_cnt[1];

endmodule

`default_nettype wire

// ==== logic/rec_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module rec_fsm
	import rec_ctrl_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_rst,
	input  key_strobe_t i_keys,
	input  logic        i_full,
	input  logic        i_end,
	output rec_state_t  o_state,
	output store_ctrl_t o_ctrl
);

	rec_state_t state;
	rec_state_t next_state;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		if (i_keys.stop) begin
			next_state = IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (i_keys.record) begin
						next_state = RECORD;
					end else if (i_keys.play) begin
						next_state = PLAY;
					end
				end
				RECORD: begin
					if (i_full) begin
						next_state = IDLE;
					end else if (i_keys.record) begin
						next_state = REC_PAUSE;
					end
				end
				REC_PAUSE: begin
					if (i_full) begin
						next_state = IDLE;
					end else if (i_keys.record) begin
						next_state = RECORD;
					end
				end
				PLAY: begin
					if (i_end) begin
						next_state = IDLE;
					end else if (i_keys.play) begin
						next_state = PLAY_PAUSE;
					end
				end
				PLAY_PAUSE: begin
					if (i_end) begin
						next_state = IDLE;
					end else if (i_keys.play) begin
						next_state = PLAY;
					end
				end
				default: next_state = IDLE;
			endcase
		end
	end

	// clears fire in the idle cycle that starts a fresh take
	always_comb begin
		o_ctrl.rec_en     = (state == RECORD);
		o_ctrl.play_en    = (state == PLAY);
		o_ctrl.rec_clear  = (state == IDLE) && (next_state == RECORD);
		o_ctrl.play_clear = (state == IDLE) && (next_state == PLAY);
	end

	assign o_state = state;

endmodule

`default_nettype wire

// ==== logic/debounce.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "recorder_consts.svh"

module debounce (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_key,
	output logic o_press
);

	localparam int CNT_W = $clog2(`DEBOUNCE_CYCLES + 1);

	logic             key_s;
	logic [CNT_W-1:0] low_cnt;
	logic             armed;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			key_s   <= 1'b1;
			low_cnt <= '0;
			armed   <= 1'b0;
			o_press <= 1'b0;
		end else begin
			key_s   <= i_key;
			o_press <= 1'b0;
			if (key_s) begin
				// released, a new press may follow
				low_cnt <= '0;
				armed   <= 1'b1;
			end else if (armed) begin
				if (low_cnt == CNT_W'(`DEBOUNCE_CYCLES - 1)) begin
					o_press <= 1'b1;
					armed   <= 1'b0;
					low_cnt <= '0;
				end else begin
					low_cnt <= low_cnt + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/audio_pkg.sv ====
`default_nettype none

package audio_pkg;

	`include "recorder_consts.svh"

	typedef logic signed [15:0] sample_t;

	typedef logic [`ADDR_W-1:0] addr_t;

	// saturates at 63, two display digits
	typedef logic [5:0] seconds_t;

endpackage

`default_nettype wire

// ==== logic/rec_ctrl_pkg.sv ====
`default_nettype none

package rec_ctrl_pkg;

	typedef enum logic [2:0] {
		IDLE,
		RECORD,
		REC_PAUSE,
		PLAY,
		PLAY_PAUSE
	} rec_state_t;

	// one-cycle press strobes from the debouncers
	typedef struct packed {
		logic record;
		logic play;
		logic stop;
	} key_strobe_t;

	// step factor is speed + 1
	typedef struct packed {
		logic       fast;
		logic [2:0] speed;
	} play_mode_t;

	typedef struct packed {
		logic rec_en;
		logic play_en;
		logic rec_clear;
		logic play_clear;
	} store_ctrl_t;

endpackage

`default_nettype wire

// ==== logic/recorder_consts.svh ====
`ifndef RECORDER_CONSTS_SVH
`define RECORDER_CONSTS_SVH

// sample memory size, one word per sample
`define MEM_DEPTH 256
`define ADDR_W 8

// kept small so one displayed second is only a few samples in simulation
`define SAMPLES_PER_TICK 16

// stable cycles before a key level is trusted
`define DEBOUNCE_CYCLES 8

`endif
